// ==== filelist.f ====
+incdir+hw
hw/avr_io_pkg.sv
hw/data_bus_arbiter.sv
hw/data_sram.sv
hw/gpio_port.sv
hw/timer8_pwm.sv
hw/avr_io_top.sv
verification/avr_io_tb.sv

// ==== hw/avr_io_params.svh ====
// Bus sizing and I/O register map of the AVR-style data bus
// Include in any file that needs widths, credit count or register addresses
`ifndef AVR_IO_PARAMS_SVH
`define AVR_IO_PARAMS_SVH

// Data bus address width
`define AVR_ADDR_W 12

// Data bus byte width
`define AVR_DATA_W 8

// Data SRAM size in bytes, covers the whole address space
`define AVR_RAM_DEPTH 4096

// Credits per master after reset, also the depth of each request queue
`define AVR_BUS_CREDITS 2

// GPIO port B, PIN at base, DDR at base+1, PORT at base+2
`define AVR_PORTB_BASE 12'h023

// GPIO port D, same layout as port B
`define AVR_PORTD_BASE 12'h029

// Timer 0 flag register
`define AVR_TIFR0_ADDR 12'h035

// Timer 0 control A, bit 0 selects the waveform mode
`define AVR_TCCR0A_ADDR 12'h044

// Timer 0 control B, bits 2..0 select the clock
`define AVR_TCCR0B_ADDR 12'h045

// Timer 0 counter
`define AVR_TCNT0_ADDR 12'h046

// Timer 0 compare A
`define AVR_OCR0A_ADDR 12'h047

// Timer 0 interrupt mask
`define AVR_TIMSK0_ADDR 12'h06E

`endif

// ==== hw/avr_io_pkg.sv ====
// Shared types of the AVR-style I/O bus and its peripherals
// Modules name these in port lists and import the package in their body
package avr_io_pkg;

	// Bus transfer direction
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

	// Bus masters, also the index of their queues in the arbiter
	typedef enum logic
	{
		MST_CPU = 1'b0,
		MST_DBG = 1'b1
	} bus_master_t;

	// Waveform mode, TCCR0A bit 0
	typedef enum logic
	{
		TIM_NORMAL   = 1'b0,
		TIM_FAST_PWM = 1'b1
	} tim_mode_t;

	// Clock select, TCCR0B bits 2..0
	typedef enum logic [2:0]
	{
		CS_STOP    = 3'd0,
		CS_DIV1    = 3'd1,
		CS_DIV8    = 3'd2,
		CS_DIV64   = 3'd3,
		CS_DIV256  = 3'd4,
		CS_DIV1024 = 3'd5
	} tim_clksel_t;

endpackage

// ==== hw/avr_io_top.sv ====
// Top of the AVR-style I/O bus with SRAM, ports B and D and timer 0
// Both masters are driven from outside through credit-based request ports
`timescale 1ns/1ps
`include "avr_io_params.svh"

module avr_io_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cpu_req_valid,
	input  avr_io_pkg::bus_op_t    cpu_req_op,
	input  logic [`AVR_ADDR_W-1:0] cpu_req_addr,
	input  logic [`AVR_DATA_W-1:0] cpu_req_wdata,
	output logic                   cpu_credit,
	output logic                   cpu_rsp_valid,
	output logic [`AVR_DATA_W-1:0] cpu_rsp_rdata,
	input  logic                   dbg_req_valid,
	input  avr_io_pkg::bus_op_t    dbg_req_op,
	input  logic [`AVR_ADDR_W-1:0] dbg_req_addr,
	input  logic [`AVR_DATA_W-1:0] dbg_req_wdata,
	output logic                   dbg_credit,
	output logic                   dbg_rsp_valid,
	output logic [`AVR_DATA_W-1:0] dbg_rsp_rdata,
	input  logic [`AVR_DATA_W-1:0] portb_in,
	output logic [`AVR_DATA_W-1:0] portb_out,
	output logic [`AVR_DATA_W-1:0] portb_oe,
	input  logic [`AVR_DATA_W-1:0] portd_in,
	output logic [`AVR_DATA_W-1:0] portd_out,
	output logic [`AVR_DATA_W-1:0] portd_oe,
	output logic                   tim_oca,
	output logic                   tim_irq
);
	import avr_io_pkg::*;

	// Shared bus from the arbiter
	logic                   bus_valid;
	bus_op_t                bus_op;
	logic [`AVR_ADDR_W-1:0] bus_addr;
	logic [`AVR_DATA_W-1:0] bus_wdata;

	// Peer returns, zero when not addressed
	logic [`AVR_DATA_W-1:0] sram_rdata;
	logic [`AVR_DATA_W-1:0] portb_rdata;
	logic [`AVR_DATA_W-1:0] portd_rdata;
	logic [`AVR_DATA_W-1:0] tim_rdata;

	data_bus_arbiter u_arbiter (
		.clk           (clk),
		.rst           (rst),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_op    (cpu_req_op),
		.cpu_req_addr  (cpu_req_addr),
		.cpu_req_wdata (cpu_req_wdata),
		.cpu_credit    (cpu_credit),
		.cpu_rsp_valid (cpu_rsp_valid),
		.cpu_rsp_rdata (cpu_rsp_rdata),
		.dbg_req_valid (dbg_req_valid),
		.dbg_req_op    (dbg_req_op),
		.dbg_req_addr  (dbg_req_addr),
		.dbg_req_wdata (dbg_req_wdata),
		.dbg_credit    (dbg_credit),
		.dbg_rsp_valid (dbg_rsp_valid),
		.dbg_rsp_rdata (dbg_rsp_rdata),
		.bus_valid     (bus_valid),
		.bus_op        (bus_op),
		.bus_addr      (bus_addr),
		.bus_wdata     (bus_wdata),
		.sram_rdata    (sram_rdata),
		.portb_rdata   (portb_rdata),
		.portd_rdata   (portd_rdata),
		.tim_rdata     (tim_rdata)
	);

	data_sram u_sram (
		.clk       (clk),
		.bus_valid (bus_valid),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.rdata     (sram_rdata)
	);

	gpio_port #(
		.base_addr (`AVR_PORTB_BASE)
	) u_portb (
		.clk       (clk),
		.rst       (rst),
		.bus_valid (bus_valid),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.rdata     (portb_rdata),
		.pin_in    (portb_in),
		.pin_out   (portb_out),
		.pin_oe    (portb_oe)
	);

	gpio_port #(
		.base_addr (`AVR_PORTD_BASE)
	) u_portd (
		.clk       (clk),
		.rst       (rst),
		.bus_valid (bus_valid),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.rdata     (portd_rdata),
		.pin_in    (portd_in),
		.pin_out   (portd_out),
		.pin_oe    (portd_oe)
	);

	timer8_pwm u_timer0 (
		.clk       (clk),
		.rst       (rst),
		.bus_valid (bus_valid),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.rdata     (tim_rdata),
		.oca       (tim_oca),
		.irq       (tim_irq)
	);

endmodule

// ==== hw/data_bus_arbiter.sv ====
// Shares the data bus between the CPU and debug ports
// Credit-based queues per master, debug first, read data ORed from all peers
`timescale 1ns/1ps
`include "avr_io_params.svh"

module data_bus_arbiter (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cpu_req_valid,
	input  avr_io_pkg::bus_op_t    cpu_req_op,
	input  logic [`AVR_ADDR_W-1:0] cpu_req_addr,
	input  logic [`AVR_DATA_W-1:0] cpu_req_wdata,
	output logic                   cpu_credit,
	output logic                   cpu_rsp_valid,
	output logic [`AVR_DATA_W-1:0] cpu_rsp_rdata,
	input  logic                   dbg_req_valid,
	input  avr_io_pkg::bus_op_t    dbg_req_op,
	input  logic [`AVR_ADDR_W-1:0] dbg_req_addr,
	input  logic [`AVR_DATA_W-1:0] dbg_req_wdata,
	output logic                   dbg_credit,
	output logic                   dbg_rsp_valid,
	output logic [`AVR_DATA_W-1:0] dbg_rsp_rdata,
	output logic                   bus_valid,
	output avr_io_pkg::bus_op_t    bus_op,
	output logic [`AVR_ADDR_W-1:0] bus_addr,
	output logic [`AVR_DATA_W-1:0] bus_wdata,
	input  logic [`AVR_DATA_W-1:0] sram_rdata,
	input  logic [`AVR_DATA_W-1:0] portb_rdata,
	input  logic [`AVR_DATA_W-1:0] portd_rdata,
	input  logic [`AVR_DATA_W-1:0] tim_rdata
);
	import avr_io_pkg::*;

	localparam int DEPTH = `AVR_BUS_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Master-side signals, indexed by bus_master_t
	logic                   req_valid [2];
	bus_op_t                req_op    [2];
	logic [`AVR_ADDR_W-1:0] req_addr  [2];
	logic [`AVR_DATA_W-1:0] req_wdata [2];
	logic                   issue     [2];
	logic                   rsp_valid [2];
	logic [`AVR_DATA_W-1:0] rsp_rdata [2];

	// Request queue storage, no reset
	bus_op_t                q_op    [2][DEPTH];
	logic [`AVR_ADDR_W-1:0] q_addr  [2][DEPTH];
	logic [`AVR_DATA_W-1:0] q_wdata [2][DEPTH];
	logic [PTR_W-1:0]       wr_ptr  [2];
	logic [PTR_W-1:0]       rd_ptr  [2];
	logic [CNT_W-1:0]       count   [2];

	bus_master_t            sel;
	logic                   rd_pend;
	bus_master_t            rd_owner;
	logic [`AVR_DATA_W-1:0] rdata_or;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign req_valid[MST_CPU] = cpu_req_valid;
	assign req_op[MST_CPU]    = cpu_req_op;
	assign req_addr[MST_CPU]  = cpu_req_addr;
	assign req_wdata[MST_CPU] = cpu_req_wdata;
	assign req_valid[MST_DBG] = dbg_req_valid;
	assign req_op[MST_DBG]    = dbg_req_op;
	assign req_addr[MST_DBG]  = dbg_req_addr;
	assign req_wdata[MST_DBG] = dbg_req_wdata;

	// Debug head always wins, CPU only when debug queue is empty
	assign issue[MST_DBG] = (count[MST_DBG] != '0);
	assign issue[MST_CPU] = (count[MST_CPU] != '0) && (count[MST_DBG] == '0);

	// Queue fill and drain, credits guarantee no overflow
	always_ff @(posedge clk)
	begin
		for (int m = 0; m < 2; m++)
		begin
			if (req_valid[m])
			begin
				q_op[m][wr_ptr[m]]    <= req_op[m];
				q_addr[m][wr_ptr[m]]  <= req_addr[m];
				q_wdata[m][wr_ptr[m]] <= req_wdata[m];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int m = 0; m < 2; m++)
		begin
			if (rst)
			begin
				wr_ptr[m] <= '0;
				rd_ptr[m] <= '0;
				count[m]  <= '0;
			end
			else
			begin
				if (req_valid[m])
					wr_ptr[m] <= ptr_next(wr_ptr[m]);
				if (issue[m])
					rd_ptr[m] <= ptr_next(rd_ptr[m]);
				count[m] <= count[m] + CNT_W'(req_valid[m]) - CNT_W'(issue[m]);
			end
		end
	end

	// Drive the winning head onto the shared bus
	always_comb
	begin
		sel       = issue[MST_DBG] ? MST_DBG : MST_CPU;
		bus_valid = issue[MST_CPU] || issue[MST_DBG];
		bus_op    = q_op[sel][rd_ptr[sel]];
		bus_addr  = q_addr[sel][rd_ptr[sel]];
		bus_wdata = q_wdata[sel][rd_ptr[sel]];
	end

	// Owner of the read in flight, one cycle deep
	always_ff @(posedge clk)
	begin
		if (rst)
			rd_pend <= 1'b0;
		else
			rd_pend <= bus_valid && (bus_op == OP_READ);
		rd_owner <= sel;
	end

	// Unaddressed peers return zero
	assign rdata_or = sram_rdata | portb_rdata | portd_rdata | tim_rdata;

	always_comb
	begin
		for (int m = 0; m < 2; m++)
		begin
			rsp_valid[m] = rd_pend && (rd_owner == bus_master_t'(m));
			rsp_rdata[m] = rsp_valid[m] ? rdata_or : '0;
		end
	end

	// Credit back on the cycle a request leaves its queue
	assign cpu_credit    = issue[MST_CPU];
	assign cpu_rsp_valid = rsp_valid[MST_CPU];
	assign cpu_rsp_rdata = rsp_rdata[MST_CPU];
	assign dbg_credit    = issue[MST_DBG];
	assign dbg_rsp_valid = rsp_valid[MST_DBG];
	assign dbg_rsp_rdata = rsp_rdata[MST_DBG];

endmodule

// ==== hw/data_sram.sv ====
// Byte-wide data SRAM on the data bus
// Owns every address with a bit set above bit 7
`timescale 1ns/1ps
`include "avr_io_params.svh"

module data_sram (
	input  logic                   clk,
	input  logic                   bus_valid,
	input  avr_io_pkg::bus_op_t    bus_op,
	input  logic [`AVR_ADDR_W-1:0] bus_addr,
	input  logic [`AVR_DATA_W-1:0] bus_wdata,
	output logic [`AVR_DATA_W-1:0] rdata
);
	import avr_io_pkg::*;

	localparam int RAM_AW = $clog2(`AVR_RAM_DEPTH);

	logic [`AVR_DATA_W-1:0] mem [`AVR_RAM_DEPTH];
	logic                   sel;
	logic [RAM_AW-1:0]      ram_addr;

	// Low 256 bytes belong to the I/O space
	assign sel      = |bus_addr[`AVR_ADDR_W-1:8];
	assign ram_addr = bus_addr[RAM_AW-1:0];

	// Write lands at the end of the issue cycle
	always_ff @(posedge clk)
	begin
		if (bus_valid && sel && (bus_op == OP_WRITE))
			mem[ram_addr] <= bus_wdata;
	end

	// Read register stays zero unless this RAM is read
	always_ff @(posedge clk)
	begin
		if (bus_valid && sel && (bus_op == OP_READ))
			rdata <= mem[ram_addr];
		else
			rdata <= '0;
	end

endmodule

// ==== hw/gpio_port.sv ====
// One 8-bit GPIO port with PIN, DDR and PORT registers
// Instantiate once per port, base_addr gives the PIN address
`timescale 1ns/1ps
`include "avr_io_params.svh"

module gpio_port #(
	parameter logic [`AVR_ADDR_W-1:0] base_addr = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   bus_valid,
	input  avr_io_pkg::bus_op_t    bus_op,
	input  logic [`AVR_ADDR_W-1:0] bus_addr,
	input  logic [`AVR_DATA_W-1:0] bus_wdata,
	output logic [`AVR_DATA_W-1:0] rdata,
	input  logic [`AVR_DATA_W-1:0] pin_in,
	output logic [`AVR_DATA_W-1:0] pin_out,
	output logic [`AVR_DATA_W-1:0] pin_oe
);
	import avr_io_pkg::*;

	// Register layout, AVR style
	localparam logic [`AVR_ADDR_W-1:0] PIN_ADDR  = base_addr;
	localparam logic [`AVR_ADDR_W-1:0] DDR_ADDR  = base_addr + 1'b1;
	localparam logic [`AVR_ADDR_W-1:0] PORT_ADDR = base_addr + 2'd2;

	logic [`AVR_DATA_W-1:0] ddr_q;
	logic [`AVR_DATA_W-1:0] port_q;
	logic                   wr;
	logic                   rd;

	assign wr = bus_valid && (bus_op == OP_WRITE);
	assign rd = bus_valid && (bus_op == OP_READ);

	// PIN is read only, writes there are dropped
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ddr_q  <= '0;
			port_q <= '0;
		end
		else if (wr)
		begin
			if (bus_addr == DDR_ADDR)
				ddr_q <= bus_wdata;
			if (bus_addr == PORT_ADDR)
				port_q <= bus_wdata;
		end
	end

	// Pins sampled at the edge closing the read's issue cycle
	always_ff @(posedge clk)
	begin
		rdata <= '0;
		if (rd)
		begin
			case (bus_addr)
				PIN_ADDR:  rdata <= pin_in;
				DDR_ADDR:  rdata <= ddr_q;
				PORT_ADDR: rdata <= port_q;
				default:   rdata <= '0;
			endcase
		end
	end

	// DDR bit set drives the pin
	assign pin_oe  = ddr_q;
	assign pin_out = port_q;

endmodule

// ==== hw/timer8_pwm.sv ====
// 8-bit timer/counter 0 with prescaler, compare A, flags and fast PWM
// Sits on the I/O bus and decodes its own register addresses
`timescale 1ns/1ps
`include "avr_io_params.svh"

module timer8_pwm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   bus_valid,
	input  avr_io_pkg::bus_op_t    bus_op,
	input  logic [`AVR_ADDR_W-1:0] bus_addr,
	input  logic [`AVR_DATA_W-1:0] bus_wdata,
	output logic [`AVR_DATA_W-1:0] rdata,
	output logic                   oca,
	output logic                   irq
);
	import avr_io_pkg::*;

	localparam int PRE_W = 10;

	tim_mode_t              mode;
	tim_clksel_t            clksel;
	logic [`AVR_DATA_W-1:0] tcnt;
	logic [`AVR_DATA_W-1:0] ocr0a;
	// Bit 0 overflow, bit 1 compare A
	logic [1:0]             timsk;
	logic [1:0]             tifr;
	logic [PRE_W-1:0]       pre;
	logic                   tick;
	logic                   cnt_en;
	logic                   wr;
	logic                   rd;
	logic [1:0]             flag_set;

	assign wr = bus_valid && (bus_op == OP_WRITE);
	assign rd = bus_valid && (bus_op == OP_READ);

	// Free-running prescaler shared by all divide ratios
	always_ff @(posedge clk)
	begin
		if (rst)
			pre <= '0;
		else
			pre <= pre + 1'b1;
	end

	always_comb
	begin
		case (clksel)
			CS_DIV1:    tick = 1'b1;
			CS_DIV8:    tick = &pre[2:0];
			CS_DIV64:   tick = &pre[5:0];
			CS_DIV256:  tick = &pre[7:0];
			CS_DIV1024: tick = &pre[9:0];
			default:    tick = 1'b0;
		endcase
	end

	// A bus write to TCNT takes the place of the count
	assign cnt_en   = tick && !(wr && (bus_addr == `AVR_TCNT0_ADDR));
	assign flag_set = {cnt_en && (tcnt == ocr0a), cnt_en && (&tcnt)};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mode   <= TIM_NORMAL;
			clksel <= CS_STOP;
			tcnt   <= '0;
			ocr0a  <= '0;
			timsk  <= '0;
			tifr   <= '0;
			oca    <= 1'b0;
		end
		else
		begin
			if (cnt_en)
				tcnt <= tcnt + 1'b1;
			// Hardware set wins over a same-cycle clear
			if (wr && (bus_addr == `AVR_TIFR0_ADDR))
				tifr <= (tifr & ~bus_wdata[1:0]) | flag_set;
			else
				tifr <= tifr | flag_set;
			if (wr)
			begin
				case (bus_addr)
					`AVR_TCCR0A_ADDR: mode   <= tim_mode_t'(bus_wdata[0]);
					`AVR_TCCR0B_ADDR: clksel <= tim_clksel_t'(bus_wdata[2:0]);
					`AVR_TCNT0_ADDR:  tcnt   <= bus_wdata;
					`AVR_OCR0A_ADDR:  ocr0a  <= bus_wdata;
					`AVR_TIMSK0_ADDR: timsk  <= bus_wdata[1:0];
					default:          ;
				endcase
			end
			// High for OCR0A counts out of 256
			oca <= (mode == TIM_FAST_PWM) && (tcnt < ocr0a);
		end
	end

	always_ff @(posedge clk)
	begin
		rdata <= '0;
		if (rd)
		begin
			case (bus_addr)
				`AVR_TCCR0A_ADDR: rdata <= {7'b0, mode};
				`AVR_TCCR0B_ADDR: rdata <= {5'b0, clksel};
				`AVR_TCNT0_ADDR:  rdata <= tcnt;
				`AVR_OCR0A_ADDR:  rdata <= ocr0a;
				`AVR_TIMSK0_ADDR: rdata <= {6'b0, timsk};
				`AVR_TIFR0_ADDR:  rdata <= {6'b0, tifr};
				default:          rdata <= '0;
			endcase
		end
	end

	// Masked flags straight from the registers
	assign irq = |(tifr & timsk);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the AVR I/O bus testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module avr_io_tb -f filelist.f -o avr_io_sim

# The log decides the result, so a failing run must not end the script here
./obj_dir/avr_io_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== verification/avr_io_tb.sv ====
// Testbench for the AVR-style I/O bus with seeded random SRAM traffic from both masters
// Also covers GPIO registers, timer overflow interrupt and fast-PWM duty against a model
`timescale 1ns/1ps
`include "avr_io_params.svh"

module avr_io_tb;
	import avr_io_pkg::*;

	localparam int CREDITS = `AVR_BUS_CREDITS;
	localparam int N_OPS   = 200;

	logic                   clk;
	logic                   rst;
	logic                   cpu_req_valid;
	bus_op_t                cpu_req_op;
	logic [`AVR_ADDR_W-1:0] cpu_req_addr;
	logic [`AVR_DATA_W-1:0] cpu_req_wdata;
	logic                   cpu_credit;
	logic                   cpu_rsp_valid;
	logic [`AVR_DATA_W-1:0] cpu_rsp_rdata;
	logic                   dbg_req_valid;
	bus_op_t                dbg_req_op;
	logic [`AVR_ADDR_W-1:0] dbg_req_addr;
	logic [`AVR_DATA_W-1:0] dbg_req_wdata;
	logic                   dbg_credit;
	logic                   dbg_rsp_valid;
	logic [`AVR_DATA_W-1:0] dbg_rsp_rdata;
	logic [`AVR_DATA_W-1:0] portb_in;
	logic [`AVR_DATA_W-1:0] portb_out;
	logic [`AVR_DATA_W-1:0] portb_oe;
	logic [`AVR_DATA_W-1:0] portd_in;
	logic [`AVR_DATA_W-1:0] portd_out;
	logic [`AVR_DATA_W-1:0] portd_oe;
	logic                   tim_oca;
	logic                   tim_irq;

	// Reference model of SRAM contents and GPIO registers
	// Index 0 is port B
	logic [`AVR_DATA_W-1:0] sram_model [`AVR_RAM_DEPTH];
	logic [`AVR_DATA_W-1:0] ddr_model  [2];
	logic [`AVR_DATA_W-1:0] port_model [2];
	// Expected read data per master in request order
	logic [`AVR_DATA_W-1:0] cpu_exp_data [$];
	logic [`AVR_DATA_W-1:0] cpu_exp_mask [$];
	logic [`AVR_DATA_W-1:0] dbg_exp_data [$];
	logic [`AVR_DATA_W-1:0] dbg_exp_mask [$];
	int                     cpu_cred;
	int                     dbg_cred;
	string                  phase;

	avr_io_top u_avr_io_top (.*);

	// 100 ns clock
	always #50 clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_rdata(input string name, input logic [`AVR_DATA_W-1:0] exp,
		input logic [`AVR_DATA_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic check_pins(input string name, input logic [`AVR_DATA_W-1:0] exp,
		input logic [`AVR_DATA_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
	endtask

	// Initial SRAM data mixing in the high address bits
	function automatic logic [`AVR_DATA_W-1:0] fill_pattern(input logic [`AVR_ADDR_W-1:0] addr);
		return addr[7:0] ^ {addr[11:8], addr[11:8]} ^ 8'hA5;
	endfunction

	// Low I/O addresses that some peer decodes
	function automatic bit is_mapped(input logic [`AVR_ADDR_W-1:0] addr);
		return (addr >= `AVR_PORTB_BASE && addr <= `AVR_PORTB_BASE + 2)
			|| (addr >= `AVR_PORTD_BASE && addr <= `AVR_PORTD_BASE + 2)
			|| (addr >= `AVR_TCCR0A_ADDR && addr <= `AVR_OCR0A_ADDR)
			|| addr == `AVR_TIFR0_ADDR || addr == `AVR_TIMSK0_ADDR;
	endfunction

	function automatic bus_master_t random_master();
		return ($urandom_range(0, 1) == 0) ? MST_CPU : MST_DBG;
	endfunction

	// Drop requests, collect credits and check responses on the falling edge
	task automatic next_cycle();
		@(negedge clk);
		cpu_req_valid = 1'b0;
		dbg_req_valid = 1'b0;
		if (cpu_credit)
			cpu_cred++;
		if (dbg_credit)
			dbg_cred++;
		if (cpu_cred > CREDITS || dbg_cred > CREDITS)
			abort_run("A master got back more credits than it spent");
		if (cpu_rsp_valid)
		begin
			if (cpu_exp_data.size() == 0)
				abort_run("CPU port returned a response with no read outstanding");
			check_rdata({phase, " cpu read"}, cpu_exp_data.pop_front(),
				cpu_rsp_rdata & cpu_exp_mask.pop_front());
		end
		if (dbg_rsp_valid)
		begin
			if (dbg_exp_data.size() == 0)
				abort_run("Debug port returned a response with no read outstanding");
			check_rdata({phase, " dbg read"}, dbg_exp_data.pop_front(),
				dbg_rsp_rdata & dbg_exp_mask.pop_front());
		end
	endtask

	// Only call right after next_cycle
	task automatic drive_req(input bus_master_t m, input bus_op_t op,
		input logic [`AVR_ADDR_W-1:0] addr, input logic [`AVR_DATA_W-1:0] wdata);
		if (m == MST_CPU)
		begin
			if (cpu_cred == 0)
				abort_run("CPU request attempted without a credit");
			cpu_cred--;
			cpu_req_valid = 1'b1;
			cpu_req_op    = op;
			cpu_req_addr  = addr;
			cpu_req_wdata = wdata;
		end
		else
		begin
			if (dbg_cred == 0)
				abort_run("Debug request attempted without a credit");
			dbg_cred--;
			dbg_req_valid = 1'b1;
			dbg_req_op    = op;
			dbg_req_addr  = addr;
			dbg_req_wdata = wdata;
		end
	endtask

	task automatic expect_read(input bus_master_t m, input logic [`AVR_DATA_W-1:0] exp,
		input logic [`AVR_DATA_W-1:0] mask);
		if (m == MST_CPU)
		begin
			cpu_exp_data.push_back(exp & mask);
			cpu_exp_mask.push_back(mask);
		end
		else
		begin
			dbg_exp_data.push_back(exp & mask);
			dbg_exp_mask.push_back(mask);
		end
	endtask

	// Wait until all credits are back and no read is outstanding
	task automatic drain();
		int cyc;
		for (cyc = 0; cpu_cred != CREDITS || dbg_cred != CREDITS
			|| cpu_exp_data.size() != 0 || dbg_exp_data.size() != 0; cyc++)
		begin
			if (cyc > 100)
				abort_run("Credits or read responses did not return in time");
			next_cycle();
		end
	endtask

	task automatic bus_write(input bus_master_t m, input logic [`AVR_ADDR_W-1:0] addr,
		input logic [`AVR_DATA_W-1:0] data);
		next_cycle();
		drive_req(m, OP_WRITE, addr, data);
		drain();
		// Credit shows in the issue cycle, the write lands at the edge closing it
		next_cycle();
	endtask

	task automatic bus_read(input bus_master_t m, input logic [`AVR_ADDR_W-1:0] addr,
		input logic [`AVR_DATA_W-1:0] exp, input logic [`AVR_DATA_W-1:0] mask);
		next_cycle();
		expect_read(m, exp, mask);
		drive_req(m, OP_READ, addr, '0);
		drain();
	endtask

	// Each master owns its own SRAM window, so request-time model data holds at issue
	task automatic issue_sram(input bus_master_t m, input bit fill, input int idx);
		logic [`AVR_ADDR_W-1:0] addr;
		logic [`AVR_DATA_W-1:0] data;
		bus_op_t                op;
		addr = (m == MST_CPU) ? 12'h100 : 12'h800;
		if (fill)
		begin
			addr = addr + `AVR_ADDR_W'(idx);
			op   = OP_WRITE;
			data = fill_pattern(addr);
		end
		else
		begin
			addr = addr + `AVR_ADDR_W'($urandom_range(0, 63));
			op   = ($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE;
			data = `AVR_DATA_W'($urandom);
		end
		if (op == OP_WRITE)
			sram_model[addr] = data;
		else
			expect_read(m, sram_model[addr], 8'hFF);
		drive_req(m, op, addr, data);
	endtask

	task automatic sram_traffic(input bit fill, input int n_ops);
		int cpu_done;
		int dbg_done;
		int cyc;
		cpu_done = 0;
		dbg_done = 0;
		for (cyc = 0; cpu_done < n_ops || dbg_done < n_ops; cyc++)
		begin
			if (cyc > 50 * n_ops)
				abort_run("SRAM traffic did not finish in time");
			next_cycle();
			if (cpu_done < n_ops && cpu_cred > 0 && $urandom_range(0, 99) < 70)
			begin
				issue_sram(MST_CPU, fill, cpu_done);
				cpu_done++;
			end
			if (dbg_done < n_ops && dbg_cred > 0 && $urandom_range(0, 99) < 40)
			begin
				issue_sram(MST_DBG, fill, dbg_done);
				dbg_done++;
			end
		end
		drain();
	endtask

	task automatic gpio_test();
		int                     port;
		bit                     is_ddr;
		logic [`AVR_ADDR_W-1:0] base;
		logic [`AVR_ADDR_W-1:0] addr;
		logic [`AVR_DATA_W-1:0] data;
		phase = "gpio";
		for (int i = 0; i < 24; i++)
		begin
			port   = $urandom_range(0, 1);
			base   = (port == 0) ? `AVR_PORTB_BASE : `AVR_PORTD_BASE;
			is_ddr = $urandom_range(0, 1);
			data   = `AVR_DATA_W'($urandom);
			bus_write(random_master(), base + (is_ddr ? 12'd1 : 12'd2), data);
			if (is_ddr)
				ddr_model[port] = data;
			else
				port_model[port] = data;
			check_pins("portb oe", ddr_model[0], portb_oe);
			check_pins("portb out", port_model[0], portb_out);
			check_pins("portd oe", ddr_model[1], portd_oe);
			check_pins("portd out", port_model[1], portd_out);
			// New pin levels held through the reads
			next_cycle();
			portb_in = `AVR_DATA_W'($urandom);
			portd_in = `AVR_DATA_W'($urandom);
			bus_read(random_master(), base, (port == 0) ? portb_in : portd_in, 8'hFF);
			bus_read(random_master(), base + 12'd1, ddr_model[port], 8'hFF);
			bus_read(random_master(), base + 12'd2, port_model[port], 8'hFF);
			addr = `AVR_ADDR_W'($urandom_range(0, 255));
			if (is_mapped(addr))
				addr = addr & 12'h01F;
			bus_read(random_master(), addr, 8'h00, 8'hFF);
		end
	endtask

	task automatic timer_irq_test();
		int cyc;
		phase = "timer irq";
		bus_write(MST_CPU, `AVR_TCCR0A_ADDR, {7'b0, TIM_NORMAL});
		bus_write(MST_CPU, `AVR_TIMSK0_ADDR, 8'h01);
		bus_write(MST_CPU, `AVR_TCNT0_ADDR, 8'h00);
		bus_write(MST_CPU, `AVR_TCCR0B_ADDR, {5'b0, CS_DIV1});
		for (cyc = 0; !tim_irq; cyc++)
		begin
			if (cyc >= 300)
				abort_run("Timer overflow interrupt did not rise within 300 cycles");
			next_cycle();
			check_flag("oca in normal mode", 1'b0, tim_oca);
		end
		// Only the overflow flag is checked since compare may also be set
		bus_read(MST_DBG, `AVR_TIFR0_ADDR, 8'h01, 8'h01);
		bus_write(MST_DBG, `AVR_TIFR0_ADDR, 8'h01);
		check_flag("irq after flag clear", 1'b0, tim_irq);
	endtask

	task automatic pwm_test();
		logic [`AVR_DATA_W-1:0] ocr;
		int                     high_cnt;
		phase = "pwm";
		ocr = `AVR_DATA_W'($urandom_range(1, 254));
		bus_write(MST_DBG, `AVR_OCR0A_ADDR, ocr);
		bus_write(MST_CPU, `AVR_TCCR0A_ADDR, {7'b0, TIM_FAST_PWM});
		// Let oca pick up the new mode
		repeat (4) next_cycle();
		high_cnt = 0;
		for (int i = 0; i < 256; i++)
		begin
			next_cycle();
			if (tim_oca)
				high_cnt++;
		end
		check_rdata("pwm high cycles in 256", ocr, `AVR_DATA_W'(high_cnt));
	endtask

	initial
	begin
		void'($urandom(56967));
		clk           = 1'b0;
		rst           = 1'b1;
		cpu_req_valid = 1'b0;
		cpu_req_op    = OP_READ;
		cpu_req_addr  = '0;
		cpu_req_wdata = '0;
		dbg_req_valid = 1'b0;
		dbg_req_op    = OP_READ;
		dbg_req_addr  = '0;
		dbg_req_wdata = '0;
		portb_in      = '0;
		portd_in      = '0;
		ddr_model     = '{default: '0};
		port_model    = '{default: '0};
		cpu_cred      = 0;
		dbg_cred      = 0;
		phase         = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst      = 1'b0;
		cpu_cred = CREDITS;
		dbg_cred = CREDITS;

		// Idle bus after reset
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			if (cpu_credit || dbg_credit || cpu_rsp_valid || dbg_rsp_valid)
				abort_run("Credit or response pulse seen on an idle bus after reset");
			check_flag("irq after reset", 1'b0, tim_irq);
			check_flag("oca after reset", 1'b0, tim_oca);
			check_pins("portb oe after reset", 8'h00, portb_oe);
			check_pins("portd oe after reset", 8'h00, portd_oe);
		end

		phase = "sram fill";
		sram_traffic(1'b1, 64);
		phase = "sram random";
		sram_traffic(1'b0, N_OPS);
		gpio_test();
		timer_irq_test();
		pwm_test();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
